/* a2_mem.f */
a2_mem_pkg.sv
mem_port_if.sv
shadow_ram.sv
mem_arbiter.sv
bus_shadow.sv
video_reader.sv
a2_mem_top.sv
a2_mem_checker.sv
tb_a2_mem.sv

/* a2_mem_checker.sv */
// Concurrent checks bound into every mem_arbiter instance
// Acks are the arbiter's own port ack vector
// Requesters must keep req high through their ack cycle

`timescale 1ns/10ps

module a2_mem_checker #(
    parameter int NUM_PORTS = 2,
    parameter int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input logic                 clk_logic_w,
    input logic                 rst_n_i,
    input logic [NUM_PORTS-1:0] req_i,
    input logic [NUM_PORTS-1:0] ack_i,
    input logic                 grant_i,
    input logic [IDX_W-1:0]     sel_idx_i    // Winner in the grant cycle
);

    int fail_count = 0;

    a_ack_onehot: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        $onehot0(ack_i))
    else begin
        fail_count = fail_count + 1;
        $error("more than one port acknowledged in the same cycle");
    end

    // Requester holds req through its ack
    a_ack_needs_req: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        (ack_i & ~req_i) == '0)
    else begin
        fail_count = fail_count + 1;
        $error("ack given to a port whose req is low");
    end

    a_grant_then_ack: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        grant_i |=> $onehot(ack_i) && ack_i[$past(sel_idx_i)])
    else begin
        fail_count = fail_count + 1;
        $error("grant not followed by an ack to the same port one cycle later");
    end

endmodule

bind mem_arbiter a2_mem_checker #(
    .NUM_PORTS(NUM_PORTS)
) arb_checker_i (
    .clk_logic_w(clk_logic_w),
    .rst_n_i    (rst_n_i),
    .req_i      (req_w),
    .ack_i      (ack_w),
    .grant_i    (grant_w),
    .sel_idx_i  (sel_idx_w)
);

/* a2_mem_pkg.sv */
// Shared widths, port numbers and memory types of the shadow memory core
// The memory is word wide, so bus byte addresses map to word plus lane
// Port numbers double as priorities, the lower number wins

package a2_mem_pkg;

    localparam int BUS_ADDR_WIDTH  = 16;
    localparam int BUS_DATA_WIDTH  = 8;
    localparam int WORD_WIDTH      = 32;
    localparam int LANES           = WORD_WIDTH / BUS_DATA_WIDTH;
    localparam int WORD_ADDR_WIDTH = BUS_ADDR_WIDTH - $clog2(LANES);   // 14 bits, 64 KB

    // Requester ports on the arbiter
    localparam int VIDEO_PORT = 0;  // Highest priority
    localparam int MAIN_PORT  = 1;
    localparam int NUM_PORTS  = 2;

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [LANES-1:0]           lane_mask_t;   // Bit 0 is the low byte
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;

endpackage

/* a2_mem_stim.txt */
# W bus_addr byte | R word_addr expected_word | P bus_addr byte word_addr expected_read
# B count first_bus_addr first_byte overflow_after, bytes and addresses count up
W 0040 11
W 0041 22
W 0042 33
W 0043 44
R 0010 44332211
W 0042 a5
R 0010 44a52211
W 00c0 01
W 00c1 02
W 00c2 03
W 00c3 04
R 0030 04030201
P 00c1 ee 0030 04030201
R 0030 0403ee01
P 0043 99 0010 44a52211
R 0010 99a52211
W 0102 62
W 0103 63
B 2 0100 60 0
R 0040 63626160
W 0200 f0
W 0201 f1
W 0202 aa
W 0203 f3
R 0080 f3aaf1f0
B 4 0200 10 1
R 0080 13aa1110
R 0010 99a52211

/* a2_mem_top.sv */
// Shadow memory core: bus write shadowing and video reads on one RAM
// Video has priority over the bus shadow on the arbiter
// Bus strobes must already be synchronous single-cycle pulses

`timescale 1ns/10ps

module a2_mem_top import a2_mem_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                      clk_logic_w,
    input  logic                      rst_n_i,

    input  logic                      bus_wr_strobe_i,
    input  logic [BUS_ADDR_WIDTH-1:0] bus_addr_i,
    input  logic [BUS_DATA_WIDTH-1:0] bus_data_i,

    input  logic                      video_rd_i,
    input  word_addr_t                video_addr_i,
    output word_t                     video_data_o,
    output logic                      video_valid_o,
    output logic                      video_busy_o,

    output logic                      shadow_overflow_o
);

    mem_port_if mem_ports [NUM_PORTS] ();

    logic       ram_en_w;
    logic       ram_we_w;
    word_addr_t ram_addr_w;
    word_t      ram_wdata_w;
    lane_mask_t ram_mask_w;
    word_t      ram_rdata_w;

    bus_shadow #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) bus_shadow_i (
        .clk_logic_w(clk_logic_w),
        .rst_n_i    (rst_n_i),
        .wr_strobe_i(bus_wr_strobe_i),
        .addr_i     (bus_addr_i),
        .data_i     (bus_data_i),
        .mem        (mem_ports[MAIN_PORT]),
        .overflow_o (shadow_overflow_o)
    );

    video_reader video_reader_i (
        .clk_logic_w(clk_logic_w),
        .rst_n_i    (rst_n_i),
        .rd_i       (video_rd_i),
        .addr_i     (video_addr_i),
        .mem        (mem_ports[VIDEO_PORT]),
        .data_o     (video_data_o),
        .valid_o    (video_valid_o),
        .busy_o     (video_busy_o)
    );

    mem_arbiter #(
        .NUM_PORTS(NUM_PORTS)
    ) mem_arbiter_i (
        .clk_logic_w(clk_logic_w),
        .rst_n_i    (rst_n_i),
        .ports      (mem_ports),
        .ram_en_o   (ram_en_w),
        .ram_we_o   (ram_we_w),
        .ram_addr_o (ram_addr_w),
        .ram_wdata_o(ram_wdata_w),
        .ram_mask_o (ram_mask_w),
        .ram_rdata_i(ram_rdata_w)
    );

    shadow_ram shadow_ram_i (
        .clk_logic_w(clk_logic_w),
        .en_i       (ram_en_w),
        .we_i       (ram_we_w),
        .addr_i     (ram_addr_w),
        .wdata_i    (ram_wdata_w),
        .mask_i     (ram_mask_w),
        .rdata_o    (ram_rdata_w)
    );

endmodule

/* bus_shadow.sv */
// Shadows Apple bus byte writes into masked word writes
// Strobes are single-cycle pulses already synchronous to clk_logic_w
// FIFO_DEPTH must be a power of two, at least 2
// A strobe that finds the FIFO full is lost and sets the sticky overflow flag

`timescale 1ns/10ps

module bus_shadow import a2_mem_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                      clk_logic_w,
    input  logic                      rst_n_i,
    input  logic                      wr_strobe_i,
    input  logic [BUS_ADDR_WIDTH-1:0] addr_i,
    input  logic [BUS_DATA_WIDTH-1:0] data_i,

    mem_port_if.requester mem,

    output logic                      overflow_o
);

    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int LANE_W = $clog2(LANES);

    typedef struct packed {
        word_addr_t                addr;
        lane_mask_t                mask;
        logic [BUS_DATA_WIDTH-1:0] data;
    } entry_t;

    entry_t fifo_r [FIFO_DEPTH];
    entry_t in_w;

    logic [PTR_W:0] wr_ptr_r;   // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr_r;
    logic           empty_w;
    logic           full_w;
    logic           push_w;
    logic           pop_w;
    logic           overflow_r;

    // Byte address to word address plus one-hot lane
    assign in_w.addr = addr_i[BUS_ADDR_WIDTH-1:LANE_W];
    assign in_w.mask = lane_mask_t'(1) << addr_i[LANE_W-1:0];
    assign in_w.data = data_i;

    assign empty_w = (wr_ptr_r == rd_ptr_r);
    assign full_w  = (wr_ptr_r[PTR_W] != rd_ptr_r[PTR_W]) &&
                     (wr_ptr_r[PTR_W-1:0] == rd_ptr_r[PTR_W-1:0]);
    assign push_w  = wr_strobe_i && !full_w;
    assign pop_w   = mem.ack && !empty_w;

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            overflow_r <= 1'b0;
        end else begin
            if (push_w)
                wr_ptr_r <= wr_ptr_r + 1'b1;
            if (pop_w)
                rd_ptr_r <= rd_ptr_r + 1'b1;
            if (wr_strobe_i && full_w)
                overflow_r <= 1'b1;   // Sticky until reset
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (push_w) begin
            fifo_r[wr_ptr_r[PTR_W-1:0]] <= in_w;
        end
    end

    // Head entry stays put until its ack
    assign mem.req   = !empty_w;
    assign mem.we    = 1'b1;
    assign mem.addr  = fifo_r[rd_ptr_r[PTR_W-1:0]].addr;
    assign mem.mask  = fifo_r[rd_ptr_r[PTR_W-1:0]].mask;
    assign mem.wdata = {LANES{fifo_r[rd_ptr_r[PTR_W-1:0]].data}};   // Byte on every lane

    assign overflow_o = overflow_r;

endmodule

/* mem_arbiter.sv */
// Fixed-priority arbiter for the shared RAM where the lowest port number wins
// One transaction in flight with grant and RAM access in one cycle and ack in the next
// A port can therefore win at most every other cycle
// A losing port just keeps req high until it is served

`timescale 1ns/10ps

module mem_arbiter import a2_mem_pkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic       clk_logic_w,
    input  logic       rst_n_i,

    mem_port_if.arbiter ports [NUM_PORTS],

    output logic       ram_en_o,
    output logic       ram_we_o,
    output word_addr_t ram_addr_o,
    output word_t      ram_wdata_o,
    output lane_mask_t ram_mask_o,
    input  word_t      ram_rdata_i
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [NUM_PORTS-1:0] req_w;
    logic [NUM_PORTS-1:0] we_w;
    word_addr_t           addr_w  [NUM_PORTS];
    word_t                wdata_w [NUM_PORTS];
    lane_mask_t           mask_w  [NUM_PORTS];
    logic [NUM_PORTS-1:0] ack_w;         // One bit per port

    logic             any_req_w;
    logic [IDX_W-1:0] sel_idx_w;     // Lowest pending port
    logic             grant_w;
    logic             busy_r;        // Ack cycle of the granted port
    logic [IDX_W-1:0] grant_idx_r;

    // Per-port fields flattened into plain vectors
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign req_w[i]   = ports[i].req;
        assign we_w[i]    = ports[i].we;
        assign addr_w[i]  = ports[i].addr;
        assign wdata_w[i] = ports[i].wdata;
        assign mask_w[i]  = ports[i].mask;

        assign ack_w[i]       = busy_r && (grant_idx_r == IDX_W'(i));
        assign ports[i].ack   = ack_w[i];
        assign ports[i].rdata = ram_rdata_i;   // Meaningful only with ack
    end

    // Scan from the top so the lowest index is the last one kept
    always_comb begin
        any_req_w = 1'b0;
        sel_idx_w = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            if (req_w[i]) begin
                any_req_w = 1'b1;
                sel_idx_w = IDX_W'(i);
            end
        end
    end

    assign grant_w = any_req_w && !busy_r;

    // RAM sees the winner's fields in the grant cycle
    assign ram_en_o    = grant_w;
    assign ram_we_o    = we_w[sel_idx_w];
    assign ram_addr_o  = addr_w[sel_idx_w];
    assign ram_wdata_o = wdata_w[sel_idx_w];
    assign ram_mask_o  = mask_w[sel_idx_w];

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            busy_r <= 1'b0;
        end else begin
            busy_r <= grant_w;   // Never two grants in a row
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (grant_w) begin
            grant_idx_r <= sel_idx_w;
        end
    end

endmodule

/* mem_port_if.sv */
// One requester's port on the memory arbiter
// Req and the fields stay stable until ack, which is a one-cycle pulse
// For a read, rdata is valid in the ack cycle only

`timescale 1ns/10ps

interface mem_port_if import a2_mem_pkg::*; ();

    logic       req;
    logic       we;     // High for write
    word_addr_t addr;
    word_t      wdata;
    lane_mask_t mask;   // Write lanes, ignored on reads
    logic       ack;
    word_t      rdata;

    modport requester (
        output req, we, addr, wdata, mask,
        input  ack, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata, mask,
        output ack, rdata
    );

endinterface

/* run_sim.sh */
#!/bin/sh
# Builds and runs tb_a2_mem with Verilator; pass or fail comes from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_a2_mem -f a2_mem.f -o sim_a2_mem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_a2_mem > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* shadow_ram.sv */
// Word-wide on-chip RAM standing in for the SDRAM
// Writes honour the byte-lane mask, reads return data one cycle later
// Contents are undefined until written

`timescale 1ns/10ps

module shadow_ram import a2_mem_pkg::*; (
    input  logic       clk_logic_w,
    input  logic       en_i,
    input  logic       we_i,
    input  word_addr_t addr_i,
    input  word_t      wdata_i,
    input  lane_mask_t mask_i,
    output word_t      rdata_o
);

    localparam int DEPTH = 2 ** WORD_ADDR_WIDTH;

    word_t mem_r [DEPTH];   // 16K words

    always_ff @(posedge clk_logic_w) begin
        if (en_i) begin
            if (we_i) begin
                // Only the selected lanes change
                for (int i = 0; i < LANES; i++) begin
                    if (mask_i[i]) begin
                        mem_r[addr_i][i*BUS_DATA_WIDTH +: BUS_DATA_WIDTH] <=
                            wdata_i[i*BUS_DATA_WIDTH +: BUS_DATA_WIDTH];
                    end
                end
            end else begin
                rdata_o <= mem_r[addr_i];   // Ready next cycle
            end
        end
    end

endmodule

/* tb_a2_mem.sv */
// Testbench for a2_mem_top, operations come from a2_mem_stim.txt in the project root
// Every word read back has had all four lanes written first
// Burst overflow levels in the stim file assume FIFO_DEPTH of 2

`timescale 1ns/10ps

module tb_a2_mem import a2_mem_pkg::*; ();

    localparam int    FIFO_DEPTH      = 2;
    localparam int    RESET_CYCLES    = 8;
    localparam int    DRAIN_CYCLES    = 4 * FIFO_DEPTH + 4;   // FIFO empty and arbiter idle
    localparam int    VALID_TIMEOUT   = 64;
    localparam int    CYCLES_PER_LINE = 200;
    localparam string STIM_FILE       = "a2_mem_stim.txt";

    logic                      clk_logic_w;
    logic                      rst_n_i;
    logic                      bus_wr_strobe_i;
    logic [BUS_ADDR_WIDTH-1:0] bus_addr_i;
    logic [BUS_DATA_WIDTH-1:0] bus_data_i;
    logic                      video_rd_i;
    word_addr_t                video_addr_i;
    word_t                     video_data_o;
    logic                      video_valid_o;
    logic                      video_busy_o;
    logic                      shadow_overflow_o;

    int          errors;
    int          stim_lines;
    logic        lines_known;
    logic [31:0] rng_state;

    a2_mem_top #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) a2_mem_top_i (
        .clk_logic_w      (clk_logic_w),
        .rst_n_i          (rst_n_i),
        .bus_wr_strobe_i  (bus_wr_strobe_i),
        .bus_addr_i       (bus_addr_i),
        .bus_data_i       (bus_data_i),
        .video_rd_i       (video_rd_i),
        .video_addr_i     (video_addr_i),
        .video_data_o     (video_data_o),
        .video_valid_o    (video_valid_o),
        .video_busy_o     (video_busy_o),
        .shadow_overflow_o(shadow_overflow_o)
    );

    initial clk_logic_w = 1'b0;
    always #4 clk_logic_w = ~clk_logic_w;   // 8 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic idle_gap();
        rng_state = xorshift32(rng_state);
        repeat (int'(rng_state[1:0])) @(posedge clk_logic_w);
    endtask

    task automatic settle();
        repeat (DRAIN_CYCLES) @(posedge clk_logic_w);
    endtask

    task automatic bus_burst(input int len, input logic [15:0] addr, input logic [7:0] data);
        for (int i = 0; i < len; i++) begin
            @(posedge clk_logic_w);
            bus_wr_strobe_i <= 1'b1;
            bus_addr_i      <= addr + 16'(i);
            bus_data_i      <= data + 8'(i);
        end
        @(posedge clk_logic_w);
        bus_wr_strobe_i <= 1'b0;
    endtask

    // Waits for the valid pulse, then checks the returned word
    task automatic read_result(input word_t exp);
        logic seen;
        int   n;
        seen = 1'b0;
        n    = 0;
        @(negedge clk_logic_w);
        check_value("video_busy_o", 32'd1, 32'(video_busy_o));
        while (!seen && n < VALID_TIMEOUT) begin
            @(negedge clk_logic_w);
            seen = video_valid_o;
            n++;
        end
        assert (seen) else begin
            errors++;
            $display("No video_valid_o pulse within %0d cycles, at %0t ns", VALID_TIMEOUT, $time);
        end
        if (seen)
            check_value("video_data_o", exp, video_data_o);
    endtask

    task automatic write_and_read(input logic [15:0] baddr, input logic [7:0] bdata,
                                  input logic [31:0] waddr, input word_t exp, input logic wr);
        @(posedge clk_logic_w);
        bus_wr_strobe_i <= wr;
        bus_addr_i      <= baddr;
        bus_data_i      <= bdata;
        video_rd_i      <= 1'b1;
        video_addr_i    <= waddr[WORD_ADDR_WIDTH-1:0];
        @(posedge clk_logic_w);
        bus_wr_strobe_i <= 1'b0;
        video_rd_i      <= 1'b0;
        read_result(exp);   // Video wins, so a same-cycle write lands afterwards
    endtask

    initial begin
        int                fd;
        int                code;
        int                len;
        logic              done;
        logic [7:0]        kind;
        logic [8*160-1:0]  line;
        logic [31:0]       a_val;
        logic [31:0]       b_val;
        logic [31:0]       c_val;
        logic [31:0]       d_val;
        errors          = 0;
        stim_lines      = 0;
        lines_known     = 1'b0;
        rng_state       = 32'd93;
        rst_n_i         = 1'b0;
        bus_wr_strobe_i = 1'b0;
        bus_addr_i      = '0;
        bus_data_i      = '0;
        video_rd_i      = 1'b0;
        video_addr_i    = '0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0)
                stim_lines++;
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
        end
        lines_known = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        rst_n_i <= 1'b1;
        @(negedge clk_logic_w);
        check_value("video_valid_o", 32'd0, 32'(video_valid_o));
        check_value("video_busy_o", 32'd0, 32'(video_busy_o));
        check_value("shadow_overflow_o", 32'd0, 32'(shadow_overflow_o));

        done = (fd == 0);
        while (!done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);   // Rest of a comment line
            end else begin
                idle_gap();
                case (kind)
                    "W": begin
                        code = $fscanf(fd, "%h %h", a_val, b_val);
                        bus_burst(1, a_val[15:0], b_val[7:0]);
                        settle();
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", a_val, b_val);
                        write_and_read('0, '0, a_val, b_val, 1'b0);
                    end
                    "B": begin
                        code = $fscanf(fd, "%d %h %h %h", len, a_val, b_val, c_val);
                        bus_burst(len, a_val[15:0], b_val[7:0]);
                        settle();
                        @(negedge clk_logic_w);
                        check_value("shadow_overflow_o", c_val, 32'(shadow_overflow_o));
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h %h %h", a_val, b_val, c_val, d_val);
                        write_and_read(a_val[15:0], b_val[7:0], c_val, d_val, 1'b1);
                        settle();
                    end
                    default: begin
                        errors++;
                        $display("Unknown operation kind in the stimulus file at %0t ns", $time);
                        done = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);

        errors = errors + a2_mem_top_i.mem_arbiter_i.arb_checker_i.fail_count;
        $display("Errors: %0d (arbiter assertions %0d)", errors,
                 a2_mem_top_i.mem_arbiter_i.arb_checker_i.fail_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Run length scales with the stim file
    initial begin
        wait (lines_known);
        repeat ((stim_lines + 1) * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clk_logic_w);
        $display("Timeout: the stimulus did not complete within %0d cycles",
                 (stim_lines + 1) * CYCLES_PER_LINE + RESET_CYCLES);
        $display("Errors: %0d", errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* video_reader.sv */
// Single-outstanding word reader for the video side
// Latency depends on contention, valid_o marks the returned word
// rd_i while busy_o is high is ignored

`timescale 1ns/10ps

module video_reader import a2_mem_pkg::*; (
    input  logic       clk_logic_w,
    input  logic       rst_n_i,
    input  logic       rd_i,
    input  word_addr_t addr_i,

    mem_port_if.requester mem,

    output word_t      data_o,
    output logic       valid_o,
    output logic       busy_o
);

    logic       req_r;
    logic       valid_r;
    logic       accept_w;
    word_addr_t addr_r;
    word_t      data_r;

    assign busy_o   = req_r || valid_r;   // Up to and including the valid cycle
    assign accept_w = rd_i && !busy_o;

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            req_r   <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            if (accept_w)
                req_r <= 1'b1;
            else if (mem.ack)
                req_r <= 1'b0;
            valid_r <= mem.ack;   // One cycle after ack
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (accept_w)
            addr_r <= addr_i;
        if (mem.ack)
            data_r <= mem.rdata;
    end

    // Read only, write fields are idle
    assign mem.req   = req_r;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_r;
    assign mem.wdata = '0;
    assign mem.mask  = '0;

    assign data_o  = data_r;
    assign valid_o = valid_r;

endmodule
